/* all.f */
rtl/dma_req_pkg.sv
rtl/dma_req_fsm.sv
rtl/dma_word_counter.sv
rtl/dma_read_fifo.sv
rtl/dma_l2r_reader.sv
tests/tb_clock_gen.sv
tests/dma_l2r_reader_tb.sv

/* tests/dma_l2r_reader_tb.sv */
`timescale 1ns/1ps

module dma_l2r_reader_tb;
  import dma_req_pkg::*;

  localparam logic [31:0] SEED = 32'h91d7_bbd4;
  localparam int N_RAND    = 6;
  // Largest word total over all requests, random lengths at most 20
  localparam int MAX_WORDS = 16 + N_RAND * 20 + 8 + 12;
  localparam int LIMIT     = 20 * MAX_WORDS + 500;
  // Consumer ready modes
  localparam int RDY_RAND  = 0;
  localparam int RDY_HIGH  = 1;
  localparam int RDY_LOW   = 2;

  logic      clk, rst;
  logic      req_start, req_is_l2r, hsel, hready;
  word_cnt_t req_size;
  addr_t     req_laddr, haddr;
  burst_t    hburst;
  data_t     hrdata, req_data;
  logic      req_data_valid, req_data_ready;

  // Reference for the open request
  addr_t     cur_base, last_addr;
  word_cnt_t cur_size;
  data_t     exp_data;
  int        first_word, total_words, stall_beats, cycles;
  int        value_errs, other_errs;
  // Phase flags sampled by the assertions
  logic      quiet, fresh_start, ready_always, stall;
  // Owned by the stimulus process
  logic [31:0] rng;
  logic        hready_rand;
  int          ready_mode;

  tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

  dma_l2r_reader dma_l2r_reader_inst (
    .clk(clk), .rst(rst),
    .req_start(req_start), .req_is_l2r(req_is_l2r),
    .req_size(req_size), .req_laddr(req_laddr),
    .hsel(hsel), .haddr(haddr), .hburst(hburst),
    .hrdata(hrdata), .hready(hready),
    .req_data_valid(req_data_valid), .req_data(req_data),
    .req_data_ready(req_data_ready)
  );

  // Memory model, every word reads back as its inverted address
  assign hrdata    = hsel ? ~haddr : '0;
  // Word k of a request is ~(laddr + 4k)
  assign exp_data  = ~(cur_base + addr_t'((total_words - first_word) * 4));
  assign last_addr = cur_base + addr_t'((int'(cur_size) - 1) * 4);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Words taken, beats during a consumer stall, run length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (rst) begin
      total_words <= 0;
      stall_beats <= 0;
    end else begin
      if (req_data_valid && req_data_ready)
        total_words <= total_words + 1;
      if (!stall)
        stall_beats <= 0;
      else if (hsel && hready)
        stall_beats <= stall_beats + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
    quiet |-> (!hsel && !req_data_valid))
    else begin
      other_errs++;
      $display("Bus or output active with no local-to-remote request open");
    end

  a_hsel_opens: assert property (@(posedge clk) disable iff (rst)
    fresh_start |=> hsel)
    else begin
      other_errs++;
      $display("hsel did not rise in the cycle after req_start");
    end

  a_word_value: assert property (@(posedge clk) disable iff (rst)
    (req_data_valid && req_data_ready) |-> (req_data == exp_data))
    else begin
      value_errs++;
      $display("Error %0t: req_data expected %h actual %h",
               $time, $sampled(exp_data), $sampled(req_data));
    end

  a_last_burst: assert property (@(posedge clk) disable iff (rst)
    (hsel && haddr == last_addr) |-> (hburst == BURST_END))
    else begin
      value_errs++;
      $display("Error %0t: hburst expected %b actual %b", $time, BURST_END, $sampled(hburst));
    end

  // Consumer never stalls here, so the burst must go on
  a_incr_burst: assert property (@(posedge clk) disable iff (rst)
    (ready_always && hsel && haddr != last_addr) |-> (hburst == BURST_INCR))
    else begin
      value_errs++;
      $display("Error %0t: hburst expected %b actual %b", $time, BURST_INCR, $sampled(hburst));
    end

  a_release: assert property (@(posedge clk) disable iff (rst)
    (hsel && hready && haddr == last_addr) |=> !hsel)
    else begin
      other_errs++;
      $display("hsel stayed high after the last beat");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    (stall && req_data_valid) |=> req_data_valid)
    else begin
      other_errs++;
      $display("req_data_valid dropped while the consumer was stalled");
    end

  a_stall_beats: assert property (@(posedge clk) disable iff (rst)
    stall |-> (stall_beats <= 3))
    else begin
      other_errs++;
      $display("More than three beats completed while the consumer was stalled");
    end

  ////////////////////////////////////////////////////////////
  // Stimulus

  // One clock step, bus and consumer readiness redrawn each edge
  task automatic tick();
    @(posedge clk);
    rng = lcg_next(rng);
    hready <= hready_rand ? rng[27] : 1'b1;
    case (ready_mode)
      RDY_RAND: req_data_ready <= rng[19];
      RDY_HIGH: req_data_ready <= 1'b1;
      default:  req_data_ready <= 1'b0;
    endcase
  endtask

  task automatic run_request(input addr_t addr, input int size, input int hold, input bit poke);
    tick();
    req_start   <= 1'b1;
    req_is_l2r  <= 1'b1;
    req_size    <= word_cnt_t'(size);
    req_laddr   <= addr;
    cur_base    <= addr;
    cur_size    <= word_cnt_t'(size);
    first_word  <= total_words;
    fresh_start <= 1'b1;
    stall       <= (hold > 0);
    tick();
    req_start   <= 1'b0;
    fresh_start <= 1'b0;
    if (poke) begin
      // Second start while the engine is busy
      tick();
      req_start <= 1'b1;
      tick();
      req_start <= 1'b0;
    end
    repeat (hold) tick();
    if (hold > 0) begin
      assert (!hsel) else begin
        other_errs++;
        $display("Bus still reading at the end of the consumer stall");
      end
      stall      <= 1'b0;
      ready_mode = RDY_HIGH;
    end
    while (total_words - first_word < size) tick();
    // Room for a stray extra word to show up
    repeat (4) tick();
    assert (total_words - first_word == size) else begin
      value_errs++;
      $display("Error %0t: word count expected %0d actual %0d",
               $time, size, total_words - first_word);
    end
  endtask

  initial begin
    req_start      = 1'b0;
    req_is_l2r     = 1'b0;
    req_size       = '0;
    req_laddr      = '0;
    hready         = 1'b0;
    req_data_ready = 1'b0;
    cur_base       = '0;
    cur_size       = '0;
    first_word     = 0;
    quiet          = 1'b1;
    fresh_start    = 1'b0;
    ready_always   = 1'b0;
    stall          = 1'b0;
    value_errs     = 0;
    other_errs     = 0;
    rng            = SEED;
    hready_rand    = 1'b0;
    ready_mode     = RDY_HIGH;

    while (rst !== 1'b0) tick();
    repeat (3) tick();
    // Remote-to-local start, engine stays idle
    req_start  <= 1'b1;
    req_is_l2r <= 1'b0;
    req_size   <= 14'd4;
    req_laddr  <= 32'h0000_0100;
    tick();
    req_start <= 1'b0;
    repeat (10) tick();
    quiet <= 1'b0;

    // Full speed, 16 words
    ready_always <= 1'b1;
    run_request(32'h0000_1000, 16, 0, 1'b0);
    ready_always <= 1'b0;

    // Random bus stalls and consumer, then a busy restart
    hready_rand = 1'b1;
    ready_mode  = RDY_RAND;
    for (int n = 0; n < N_RAND; n++)
      run_request(rng & 32'hffff_fffc, int'(rng[23:16] % 20) + 1, 0, 1'b0);
    run_request(32'h0004_0000, 8, 0, 1'b1);

    // Consumer held off for 30 cycles
    hready_rand = 1'b0;
    ready_mode  = RDY_LOW;
    run_request(32'h0008_0ff0, 12, 30, 1'b0);

    $display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) @(posedge clk);
    $display("Timeout after %0d cycles, transfer never completed", cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);
  localparam int HALF_NS      = 10;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // Reset drops on a rising edge, like the DUT's synchronous reset expects
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* rtl/dma_l2r_reader.sv */
`timescale 1ns/1ps

module dma_l2r_reader (
  input  logic                   clk,
  input  logic                   rst,

  // Request side
  input  logic                   req_start,
  input  logic                   req_is_l2r,
  input  dma_req_pkg::word_cnt_t req_size,
  input  dma_req_pkg::addr_t     req_laddr,

  // Local memory read port
  output logic                   hsel,
  output dma_req_pkg::addr_t     haddr,
  output dma_req_pkg::burst_t    hburst,
  input  dma_req_pkg::data_t     hrdata,
  input  logic                   hready,

  // Network side
  output logic                   req_data_valid,
  output dma_req_pkg::data_t     req_data,
  input  logic                   req_data_ready
);

  ////////////////////////////////////////////////////////////
  // Internal strobes

  // State machine to counter
  logic count_clr;
  logic count_inc;
  // State machine to queue
  logic fifo_push;
  // Back to the state machine
  logic last_word;
  logic fifo_room;

  ////////////////////////////////////////////////////////////
  // Bus control

  dma_req_fsm dma_req_fsm_inst (
    .clk        (clk),
    .rst        (rst),
    .req_start  (req_start),
    .req_is_l2r (req_is_l2r),
    .hready     (hready),
    .last_word  (last_word),
    .fifo_room  (fifo_room),
    .hsel       (hsel),
    .hburst     (hburst),
    .count_clr  (count_clr),
    .count_inc  (count_inc),
    .fifo_push  (fifo_push)
  );

  ////////////////////////////////////////////////////////////
  // Word index and bus address

  dma_word_counter dma_word_counter_inst (
    .clk       (clk),
    .rst       (rst),
    .count_clr (count_clr),
    .count_inc (count_inc),
    .req_size  (req_size),
    .req_laddr (req_laddr),
    .haddr     (haddr),
    .last_word (last_word)
  );

  ////////////////////////////////////////////////////////////
  // Queue between bus and network

  // Read data enters in the beat cycle, visible on req_data one cycle later
  dma_read_fifo dma_read_fifo_inst (
    .clk   (clk),
    .rst   (rst),
    .push  (fifo_push),
    .din   (hrdata),
    .pop   (req_data_ready),
    .dout  (req_data),
    .valid (req_data_valid),
    .room  (fifo_room)
  );

endmodule

/* rtl/dma_read_fifo.sv */
`timescale 1ns/1ps

module dma_read_fifo (
  input  logic               clk,
  input  logic               rst,
  // Write side, from the bus
  input  logic               push,
  input  dma_req_pkg::data_t din,
  // Read side, to the network
  input  logic               pop,
  output dma_req_pkg::data_t dout,
  output logic               valid,
  // High-water flag back to the state machine
  output logic               room
);
  import dma_req_pkg::*;

  // Three slots, slot 0 is the head
  data_t      entry [0:2];
  // One-hot write position
  // bit 0 empty, bit 3 full
  logic [3:0] pos;
  logic       pop_ok;

  assign valid  = ~pos[0];
  // Ready while empty is ignored
  assign pop_ok = pop & valid;
  assign dout   = entry[0];

  // Room only from the registered position, no path from pop.
  // One slot stays spare for the beat already in flight
  assign room = ~|pos[3:2];

  ////////////////////////////////////////////////////////////
  // Position register

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push && !pop_ok) begin
      pos <= pos << 1;
    end else if (!push && pop_ok) begin
      pos <= pos >> 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Data slots

  for (genvar i = 0; i < 3; i++) begin : g_slot
    data_t above;

    // Value shifted down into this slot on a pop
    if (i < 2) begin : g_shift
      assign above = entry[i+1];
    end else begin : g_top
      // Top slot has nothing above, it keeps its stale word
      assign above = entry[i];
    end

    always_ff @(posedge clk) begin
      if (pop_ok && push && pos[i+1]) begin
        // Push lands in the slot freed by the pop
        entry[i] <= din;
      end else if (pop_ok) begin
        entry[i] <= above;
      end else if (push && pos[i]) begin
        entry[i] <= din;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks

  // High-water mark upstream must keep the queue from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> !pos[3])
    else $error("push into a full queue");

  // Also catches a shift below empty
  a_pos_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot(pos))
    else $error("queue position lost its one-hot form");

endmodule

/* rtl/dma_word_counter.sv */
`timescale 1ns/1ps

module dma_word_counter (
  input  logic                   clk,
  input  logic                   rst,
  // Strobes from the state machine
  input  logic                   count_clr,
  input  logic                   count_inc,
  // Request fields, stable for the whole transfer
  input  dma_req_pkg::word_cnt_t req_size,
  input  dma_req_pkg::addr_t     req_laddr,
  // Bus address and end flag
  output dma_req_pkg::addr_t     haddr,
  output logic                   last_word
);
  import dma_req_pkg::*;

  // Index of the word currently on the bus
  word_cnt_t count;
  addr_t     byte_offset;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (count_clr) begin
      count <= '0;
    end else if (count_inc) begin
      count <= count + 1'b1;
    end
  end

  // Word index to byte offset, always word aligned
  assign byte_offset = addr_t'({count, 2'b00});
  assign haddr       = req_laddr + byte_offset;

  // Final word of the request
  assign last_word = (count == word_cnt_t'(req_size - 1'b1));

  ////////////////////////////////////////////////////////////
  // Checks

  // State machine must stop on last_word, never run past the length
  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    count_inc |-> (count < req_size))
    else $error("count_inc with count already at req_size");

endmodule

/* rtl/dma_req_fsm.sv */
`timescale 1ns/1ps

module dma_req_fsm (
  input  logic                clk,
  input  logic                rst,
  // Request side
  input  logic                req_start,
  input  logic                req_is_l2r,
  // Bus handshake from memory
  input  logic                hready,
  // Status from the counter and the queue
  input  logic                last_word,
  input  logic                fifo_room,
  // Bus control
  output logic                hsel,
  output dma_req_pkg::burst_t hburst,
  // Strobes to the counter and the queue
  output logic                count_clr,
  output logic                count_inc,
  output logic                fifo_push
);
  import dma_req_pkg::*;

  req_state_t state;
  req_state_t state_nxt;

  ////////////////////////////////////////////////////////////
  // Next state and outputs

  always_comb begin
    // Defaults, bus idle and no strobes
    state_nxt = state;
    hsel      = 1'b0;
    hburst    = '0;
    count_clr = 1'b0;
    count_inc = 1'b0;
    fifo_push = 1'b0;

    case (state)
      REQ_IDLE: begin
        // Only local-to-remote starts open a burst
        if (req_start && req_is_l2r) begin
          count_clr = 1'b1;
          state_nxt = REQ_DATA;
        end
      end
      REQ_DATA: begin
        hsel = 1'b1;
        // Close the burst one beat early when the queue is filling up
        if (!fifo_room || last_word) begin
          hburst = BURST_END;
        end else begin
          hburst = BURST_INCR;
        end
        // Beat completes, word goes into the queue
        if (hready) begin
          count_inc = 1'b1;
          fifo_push = 1'b1;
          if (last_word) begin
            state_nxt = REQ_IDLE;
          end else if (!fifo_room) begin
            state_nxt = REQ_WAIT;
          end
        end
      end
      REQ_WAIT: begin
        // Reopen once the queue drains below the mark
        if (fifo_room) begin
          state_nxt = REQ_DATA;
        end
      end
      default: begin
        state_nxt = REQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= REQ_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks

  // Queue is only written by a bus beat
  a_push_in_data: assert property (@(posedge clk) disable iff (rst)
    fifo_push |-> (state == REQ_DATA))
    else $error("fifo_push outside REQ_DATA");

endmodule

/* rtl/dma_req_pkg.sv */
package dma_req_pkg;

  ////////////////////////////////////////////////////////////
  // Widths

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // Request length is counted in words
  localparam int SIZE_W = 14;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SIZE_W-1:0] word_cnt_t;

  ////////////////////////////////////////////////////////////
  // Bus burst codes

  typedef logic [2:0] burst_t;

  // Burst goes on after this beat
  localparam burst_t BURST_INCR = 3'b010;
  // This beat closes the burst
  localparam burst_t BURST_END  = 3'b111;

  // Read requester states
  typedef enum logic [1:0] {
    REQ_IDLE = 2'b00,
    REQ_DATA = 2'b01,
    REQ_WAIT = 2'b10
  } req_state_t;

endpackage
